//--- modrm_frontend.f
verilog/modrm_pkg.sv
verilog/prefetch_queue.sv
verilog/operand_fetch.sv
verilog/modrm_decode.sv
verilog/reg_file.sv
verilog/modrm_frontend.sv
testbench/modrm_frontend_tb.sv

//--- testbench/modrm_frontend_tb.sv
module modrm_frontend_tb import modrm_pkg::*; ();

logic clk;
logic reset;
logic push;
logic [7:0] push_data;
logic full;
logic start;
logic complete;
modrm_result_t result;
logic reg_wr_en;
reg_name_e reg_wr_sel;
logic [15:0] reg_wr_data;

logic [31:0] lcg_state = 32'h55b0_9409;
logic [15:0] reg_model [8];
bit all_pushed;
int cycle_count = 0;
// 22 decodes in all, each well inside 40 cycles
int cycle_limit = 4 + 40 * 22;

modrm_frontend dut_i (.*);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
        $display("Timeout after %0d cycles, a decode never completed", cycle_count);
        $display(">>> FAIL");
        $fatal(1);
    end
end

function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
endfunction

// Displacement bytes that follow a ModRM byte
function automatic int disp_bytes(input logic [7:0] m);
    if (m[7:6] == 2'b01)
        return 1;
    if (m[7:6] == 2'b10 || (m[7:6] == 2'b00 && m[2:0] == 3'b110))
        return 2;
    return 0;
endfunction

function automatic modrm_result_t reference_result(input logic [7:0] m,
                                                   input logic [15:0] disp);
    modrm_result_t r;
    logic [15:0] base;
    logic [15:0] index;
    logic [15:0] offset;
    r.regnum = m[5:3];
    r.rm_regnum = m[2:0];
    r.rm_is_reg = m[7:6] == 2'b11;
    r.has_displacement = !r.rm_is_reg && disp_bytes(m) != 0;
    index = 16'h0000;
    case (m[2:0])
        3'd0: begin
            base = reg_model[BX];
            index = reg_model[SI];
        end
        3'd1: begin
            base = reg_model[BX];
            index = reg_model[DI];
        end
        3'd2: begin
            base = reg_model[BP];
            index = reg_model[SI];
        end
        3'd3: begin
            base = reg_model[BP];
            index = reg_model[DI];
        end
        3'd4: base = reg_model[SI];
        3'd5: base = reg_model[DI];
        3'd6: base = reg_model[BP];
        default: base = reg_model[BX];
    endcase
    offset = (m[7:6] == 2'b01) ? {{8{disp[7]}}, disp[7:0]} : disp;
    if (!r.has_displacement)
        offset = 16'h0000;
    if (m[7:6] == 2'b00 && m[2:0] == 3'b110)
        r.effective_address = disp;
    else
        r.effective_address = base + index + offset;
    return r;
endfunction

task automatic step();
    @(posedge clk);
    #1;
endtask

task automatic check_value(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    assert (actual === expected) else begin
        $display("** Error: %s expected 0x%h, actual 0x%h", name, expected, actual);
        $display(">>> FAIL");
        $fatal(1);
    end
endtask

task automatic load_regs();
    for (int i = 0; i < 8; i++) begin
        reg_model[i] = next_random();
        reg_wr_en = 1'b1;
        reg_wr_sel = reg_name_e'(i);
        reg_wr_data = reg_model[i];
        step();
    end
    reg_wr_en = 1'b0;
endtask

task automatic push_byte(input logic [7:0] value);
    push = 1'b1;
    push_data = value;
    step();
    push = 1'b0;
endtask

task automatic push_instruction(input logic [7:0] m, input logic [15:0] disp);
    push_byte(m);
    if (disp_bytes(m) > 0)
        push_byte(disp[7:0]);
    if (disp_bytes(m) == 2)
        push_byte(disp[15:8]);
endtask

// Latency counts whole cycles from the cycle in which start rises
task automatic wait_complete(output int latency);
    latency = 0;
    @(negedge clk);
    while (!complete) begin
        latency++;
        @(negedge clk);
    end
endtask

task automatic decode_and_check(input logic [7:0] m, input logic [15:0] disp,
                                input bit check_latency);
    modrm_result_t expected;
    int latency;
    int exp_latency;
    expected = reference_result(m, disp);
    exp_latency = (m[7:6] == 2'b11) ? 1 : (disp_bytes(m) == 2) ? 3 : 2;
    start = 1'b1;
    wait_complete(latency);
    assert (all_pushed) else begin
        $display("complete rose before the last displacement byte was pushed");
        $display(">>> FAIL");
        $fatal(1);
    end
    check_value("regnum", 16'(expected.regnum), 16'(result.regnum));
    check_value("rm_is_reg", 16'(expected.rm_is_reg), 16'(result.rm_is_reg));
    check_value("rm_regnum", 16'(expected.rm_regnum), 16'(result.rm_regnum));
    check_value("has_displacement", 16'(expected.has_displacement),
                16'(result.has_displacement));
    if (!expected.rm_is_reg)
        check_value("effective_address", expected.effective_address,
                    result.effective_address);
    assert (!check_latency || latency == exp_latency) else begin
        $display("complete came %0d cycles after the ModRM pop instead of %0d",
                 latency, exp_latency);
        $display(">>> FAIL");
        $fatal(1);
    end
    step();
    start = 1'b0;
    step();
endtask

task automatic run_test(input logic [7:0] m, input logic [15:0] disp);
    load_regs();
    push_instruction(m, disp);
    decode_and_check(m, disp, 1'b1);
endtask

// Start waits on an empty queue while the bytes trickle in
task automatic starved_decode(input logic [7:0] m, input logic [15:0] disp);
    all_pushed = 1'b0;
    fork
        begin
            push_byte(m);
            repeat (3) step();
            push_byte(disp[7:0]);
            repeat (3) step();
            all_pushed = 1'b1;
            push_byte(disp[15:8]);
        end
        decode_and_check(m, disp, 1'b0);
    join
endtask

initial begin
    logic [15:0] r;
    logic [15:0] d;
    logic [7:0] q_modrm [3];
    logic [15:0] q_disp [3];
    reset = 1'b1;
    push = 1'b0;
    push_data = 8'h00;
    start = 1'b0;
    reg_wr_en = 1'b0;
    reg_wr_sel = AX;
    reg_wr_data = 16'h0000;
    all_pushed = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    step();

    for (int i = 0; i < 4; i++) begin
        r = next_random();
        run_test({2'b11, r[5:0]}, 16'h0000);
    end
    for (int rm = 0; rm < 8; rm++) begin
        r = next_random();
        if (rm != 6)
            run_test({2'b00, r[2:0], 3'(rm)}, 16'h0000);
    end
    for (int i = 0; i < 2; i++) begin
        r = next_random();
        run_test({2'b00, r[2:0], 3'b110}, next_random());
    end
    // Negative 8-bit displacements starting with both ends of the range
    for (int i = 0; i < 4; i++) begin
        r = next_random();
        d = (i == 0) ? 16'h0080 : (i == 1) ? 16'h00ff : {8'h00, 1'b1, r[14:8]};
        run_test({2'b01, r[5:0]}, d);
    end
    for (int i = 0; i < 2; i++) begin
        r = next_random();
        load_regs();
        starved_decode({2'b10, r[5:0]}, next_random());
    end

    // Three instructions of 1, 2 and 3 bytes fill the six entry queue
    r = next_random();
    q_modrm[0] = {2'b11, r[5:0]};
    q_modrm[1] = {2'b01, r[11:6]};
    q_modrm[2] = {2'b00, r[14:12], 3'b110};
    q_disp[0] = 16'h0000;
    q_disp[1] = next_random();
    q_disp[2] = next_random();
    load_regs();
    for (int i = 0; i < 3; i++)
        push_instruction(q_modrm[i], q_disp[i]);
    @(negedge clk);
    check_value("full", 16'h0001, 16'(full));
    step();
    for (int i = 0; i < 3; i++)
        decode_and_check(q_modrm[i], q_disp[i], 1'b1);

    $display(">>> PASS");
    $finish;
end

endmodule

//--- verilog/modrm_decode.sv
module modrm_decode import modrm_pkg::*; (
    input logic clk,
    input logic reset,
    // Caller handshake
    input logic start,
    output logic complete,
    output modrm_result_t result,
    // ModRM byte from the fetch unit
    output logic modrm_rd_en,
    input logic [7:0] modrm_rd_data,
    input logic empty,
    // Displacement from the fetch unit
    output logic disp_start,
    output logic disp_is_8bit,
    input logic disp_complete,
    input logic [15:0] displacement,
    // Register file read ports, base then index
    output reg_name_e sel [2],
    input logic [15:0] regs [2]
);

modrm_byte_u modrm_q;
modrm_byte_u modrm;
logic taken;
logic byte_valid;
logic byte_held;
logic have_byte;
logic has_address;
logic has_disp;
logic direct;
logic [15:0] index_val;
logic [15:0] disp_val;

// One pop per request; a start with the queue empty just waits
assign modrm_rd_en = start & ~taken & ~empty;
assign have_byte = byte_valid | byte_held;

// While the byte is on the read port use it directly, later the held copy
always_comb begin
    modrm.raw = byte_valid ? modrm_rd_data : modrm_q.raw;
end

assign has_address = modrm.fields.mod != 2'b11;
assign direct = modrm.fields.mod == 2'b00 && modrm.fields.rm == 3'b110;

always_comb begin
    case (modrm.fields.mod)
        2'b00: has_disp = modrm.fields.rm == 3'b110;
        2'b01: has_disp = 1'b1;
        2'b10: has_disp = 1'b1;
        default: has_disp = 1'b0;
    endcase
end

assign disp_start = start & have_byte & has_disp;
assign disp_is_8bit = modrm.fields.mod == 2'b01;

// Memory operands wait one cycle for the register read after the byte is held
always_comb begin
    if (!has_address)
        complete = start & have_byte;
    else
        complete = start & byte_held & (~has_disp | disp_complete);
end

always_comb begin
    case (modrm.fields.rm)
        3'b000, 3'b001, 3'b111: sel[0] = BX;
        3'b010, 3'b011, 3'b110: sel[0] = BP;
        3'b100: sel[0] = SI;
        default: sel[0] = DI;
    endcase

    case (modrm.fields.rm)
        3'b000, 3'b010: sel[1] = SI;
        3'b001, 3'b011: sel[1] = DI;
        default: sel[1] = AX;
    endcase
end

// Only rm 000 to 011 carry an index register
assign index_val = modrm.fields.rm[2] ? 16'h0000 : regs[1];
assign disp_val = has_disp ? displacement : 16'h0000;

always_comb begin
    result.regnum = modrm.fields.reg_field;
    result.rm_regnum = modrm.fields.rm;
    result.rm_is_reg = ~has_address;
    result.has_displacement = has_disp;

    if (!has_address)
        result.effective_address = 16'h0000;
    else if (direct)
        result.effective_address = disp_val;
    else
        result.effective_address = regs[0] + index_val + disp_val;
end

always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        taken <= 1'b0;
        byte_valid <= 1'b0;
        byte_held <= 1'b0;
    end else begin
        byte_valid <= modrm_rd_en;

        // The caller drops start after complete, which frees us for the next byte
        if (!start) begin
            taken <= 1'b0;
            byte_held <= 1'b0;
        end else begin
            if (modrm_rd_en)
                taken <= 1'b1;
            if (byte_valid)
                byte_held <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (byte_valid)
        modrm_q.raw <= modrm_rd_data;
end

endmodule

//--- verilog/modrm_frontend.sv
module modrm_frontend import modrm_pkg::*; (
    input logic clk,
    input logic reset,
    // Instruction byte input
    input logic push,
    input logic [7:0] push_data,
    output logic full,
    // Decode request
    input logic start,
    output logic complete,
    output modrm_result_t result,
    // Register load port
    input logic reg_wr_en,
    input reg_name_e reg_wr_sel,
    input logic [15:0] reg_wr_data
);

logic rd_en;
logic [7:0] rd_data;
logic empty;
logic modrm_rd_en;
logic [7:0] modrm_rd_data;
logic disp_start;
logic disp_is_8bit;
logic disp_complete;
logic [15:0] displacement;
reg_name_e sel [2];
logic [15:0] regs [2];

prefetch_queue queue_i (
    .clk(clk),
    .reset(reset),
    .push(push),
    .push_data(push_data),
    .full(full),
    .rd_en(rd_en),
    .rd_data(rd_data),
    .empty(empty)
);

operand_fetch fetch_i (
    .clk(clk),
    .reset(reset),
    .rd_en(rd_en),
    .rd_data(rd_data),
    .empty(empty),
    .modrm_rd_en(modrm_rd_en),
    .modrm_rd_data(modrm_rd_data),
    .disp_start(disp_start),
    .disp_is_8bit(disp_is_8bit),
    .disp_complete(disp_complete),
    .displacement(displacement)
);

modrm_decode decode_i (
    .clk(clk),
    .reset(reset),
    .start(start),
    .complete(complete),
    .result(result),
    .modrm_rd_en(modrm_rd_en),
    .modrm_rd_data(modrm_rd_data),
    .empty(empty),
    .disp_start(disp_start),
    .disp_is_8bit(disp_is_8bit),
    .disp_complete(disp_complete),
    .displacement(displacement),
    .sel(sel),
    .regs(regs)
);

reg_file regs_i (
    .clk(clk),
    .reset(reset),
    .wr_en(reg_wr_en),
    .wr_sel(reg_wr_sel),
    .wr_data(reg_wr_data),
    .sel(sel),
    .regs(regs)
);

endmodule

//--- verilog/modrm_pkg.sv
package modrm_pkg;

// General register numbers as they appear in the ModRM reg and rm fields
typedef enum logic [2:0] {
    AX = 3'd0,
    CX = 3'd1,
    DX = 3'd2,
    BX = 3'd3,
    SP = 3'd4,
    BP = 3'd5,
    SI = 3'd6,
    DI = 3'd7
} reg_name_e;

// Prefetch queue geometry
localparam int queue_depth = 6;
localparam int queue_ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
localparam int queue_count_w = $clog2(queue_depth + 1);

// Field view of the ModRM byte, most significant field first
typedef struct packed {
    logic [1:0] mod;
    logic [2:0] reg_field;
    logic [2:0] rm;
} modrm_fields_t;

// The ModRM byte is moved around whole and decoded by field
typedef union packed {
    logic [7:0] raw;
    modrm_fields_t fields;
} modrm_byte_u;

// Decoded operand description handed back to the caller
typedef struct packed {
    logic [15:0] effective_address;
    logic [2:0] regnum;
    logic rm_is_reg;
    logic [2:0] rm_regnum;
    logic has_displacement;
} modrm_result_t;

endpackage

//--- verilog/operand_fetch.sv
module operand_fetch import modrm_pkg::*; (
    input logic clk,
    input logic reset,
    // Queue read port
    output logic rd_en,
    input logic [7:0] rd_data,
    input logic empty,
    // ModRM byte requests from the decoder
    input logic modrm_rd_en,
    output logic [7:0] modrm_rd_data,
    // Displacement requests from the decoder
    input logic disp_start,
    input logic disp_is_8bit,
    output logic disp_complete,
    output logic [15:0] displacement
);

logic disp_pop;
logic pending;
logic final_byte;
logic [1:0] issued;
logic [1:0] received;
logic [1:0] needed;
logic [7:0] low_byte;
logic [15:0] assembled;
logic [15:0] disp_q;

assign needed = disp_is_8bit ? 2'd1 : 2'd2;

// The decoder's pop always wins the read port
assign disp_pop = disp_start & ~empty & ~modrm_rd_en & (issued < needed);
assign rd_en = modrm_rd_en | disp_pop;

// The ModRM byte comes straight from the queue read data
assign modrm_rd_data = rd_data;

// Bytes arrive low first, so the last one completes the value
assign final_byte = pending & ((received + 2'd1) == needed);

always_comb begin
    if (disp_is_8bit)
        assembled = {{8{rd_data[7]}}, rd_data};
    else
        assembled = {rd_data, low_byte};
end

assign disp_complete = disp_start & (final_byte | (received == needed));
assign displacement = final_byte ? assembled : disp_q;

always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        pending <= 1'b0;
        issued <= 2'd0;
        received <= 2'd0;
    end else begin
        pending <= disp_pop;

        if (!disp_start) begin
            issued <= 2'd0;
            received <= 2'd0;
        end else begin
            if (disp_pop)
                issued <= issued + 2'd1;
            if (pending)
                received <= received + 2'd1;
        end
    end
end

always_ff @(posedge clk) begin
    if (pending && received == 2'd0)
        low_byte <= rd_data;
    if (final_byte)
        disp_q <= assembled;
end

endmodule

//--- verilog/prefetch_queue.sv
module prefetch_queue import modrm_pkg::*; (
    input logic clk,
    input logic reset,
    // Write side
    input logic push,
    input logic [7:0] push_data,
    output logic full,
    // Read side
    input logic rd_en,
    output logic [7:0] rd_data,
    output logic empty
);

logic [7:0] mem [queue_depth];
logic [queue_ptr_w-1:0] wr_ptr;
logic [queue_ptr_w-1:0] rd_ptr;
logic [queue_count_w-1:0] count;
logic push_ok;
logic pop_ok;

assign full = count == queue_count_w'(queue_depth);
assign empty = count == '0;

// A push into a full queue is dropped
assign push_ok = push & ~full;
assign pop_ok = rd_en & ~empty;

always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
    end else begin
        if (push_ok) begin
            if (wr_ptr == queue_ptr_w'(queue_depth - 1))
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;
        end

        if (pop_ok) begin
            if (rd_ptr == queue_ptr_w'(queue_depth - 1))
                rd_ptr <= '0;
            else
                rd_ptr <= rd_ptr + 1'b1;
        end

        case ({push_ok, pop_ok})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (push_ok)
        mem[wr_ptr] <= push_data;
end

// Head byte shows up the cycle after the pop
always_ff @(posedge clk) begin
    if (pop_ok)
        rd_data <= mem[rd_ptr];
end

endmodule

//--- verilog/reg_file.sv
module reg_file import modrm_pkg::*; (
    input logic clk,
    input logic reset,
    // Load port
    input logic wr_en,
    input reg_name_e wr_sel,
    input logic [15:0] wr_data,
    // Read ports
    input reg_name_e sel [2],
    output logic [15:0] regs [2]
);

logic [15:0] gpr [8];

always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        for (int i = 0; i < 8; i++)
            gpr[i] <= 16'h0000;
    end else if (wr_en) begin
        gpr[wr_sel] <= wr_data;
    end
end

// Reads are combinational so the decoder sees values in the select cycle
always_comb begin
    regs[0] = gpr[sel[0]];
    regs[1] = gpr[sel[1]];
end

endmodule
